// ==== design/maze_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 320x240 canvas, 3-bit colour, 29x13 maze of 8x8 tiles
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package maze_pkg;

	// visible canvas
	localparam int SCREEN_W = 320;
	localparam int SCREEN_H = 240;

	// maze geometry
	localparam int TILE_SIZE = 8;
	localparam int MAZE_COLS = 29;
	localparam int MAZE_ROWS = 13;

	localparam int X_BITS = 9;
	localparam int Y_BITS = 8;
	localparam int COLOR_BITS = 3;
	localparam int CANVAS_ADDR_BITS = 17; // y * SCREEN_W + x

	localparam int OFFSET_BITS = 3;   // pixel offset inside a tile
	localparam int COL_BITS = 5;      // tile column index
	localparam int MAP_ADDR_BITS = 4; // tile row index, one ROM word per row

	localparam logic [COLOR_BITS-1:0] WALL_COLOR = 3'b111;
	localparam logic [COLOR_BITS-1:0] FLOOR_COLOR = 3'b000;

	typedef logic [6:0] seg_t; // active low, bit 6 is segment g

	typedef logic [MAZE_COLS-1:0] map_row_t; // bit n is tile column n

	typedef struct packed {
		logic [X_BITS-1:0] x;
		logic [Y_BITS-1:0] y;
	} coord_t;

	typedef struct packed {
		coord_t pos;
		logic [COLOR_BITS-1:0] color;
	} pixel_t;

endpackage

// ==== design/coord_entry.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// y keeps 7 switch bits, x keeps 8; top bit of each reads zero
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module coord_entry import maze_pkg::*; (
	input logic clock,
	input logic resetn,
	input logic [7:0] switches,
	input logic load_y,
	input logic load_x,
	output coord_t origin,
	output seg_t hex_x_hi,
	output seg_t hex_x_lo,
	output seg_t hex_y_hi,
	output seg_t hex_y_lo
);

	// hex digit to active-low segments, g down to a
	function automatic seg_t hex_to_seg(input logic [3:0] value);
		case (value)
			4'h0: hex_to_seg = 7'b1000000;
			4'h1: hex_to_seg = 7'b1111001;
			4'h2: hex_to_seg = 7'b0100100;
			4'h3: hex_to_seg = 7'b0110000;
			4'h4: hex_to_seg = 7'b0011001;
			4'h5: hex_to_seg = 7'b0010010;
			4'h6: hex_to_seg = 7'b0000010;
			4'h7: hex_to_seg = 7'b1111000;
			4'h8: hex_to_seg = 7'b0000000;
			4'h9: hex_to_seg = 7'b0010000;
			4'ha: hex_to_seg = 7'b0001000;
			4'hb: hex_to_seg = 7'b0000011;
			4'hc: hex_to_seg = 7'b1000110;
			4'hd: hex_to_seg = 7'b0100001;
			4'he: hex_to_seg = 7'b0000110;
			default: hex_to_seg = 7'b0001110;
		endcase
	endfunction

	always_ff @(posedge clock) begin
		if (!resetn) begin
			origin <= '0;
		end else begin
			if (load_y)
				origin.y <= {1'b0, switches[6:0]};
			if (load_x)
				origin.x <= {1'b0, switches[7:0]};
		end
	end

	// digits track the registers directly
	assign hex_x_hi = hex_to_seg(origin.x[7:4]);
	assign hex_x_lo = hex_to_seg(origin.x[3:0]);
	assign hex_y_hi = hex_to_seg({1'b0, origin.y[6:4]}); // y stays below 128
	assign hex_y_lo = hex_to_seg(origin.y[3:0]);

endmodule

// ==== design/maze_map_rom.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// contents come from maze.mem at elaboration; rows past 12 are undefined
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module maze_map_rom import maze_pkg::*; (
	input logic clock,
	input logic [MAP_ADDR_BITS-1:0] row_addr,
	output map_row_t row_data
);

	map_row_t rom [MAZE_ROWS];

	// one text line per maze row, rightmost digit is column 0
	initial begin
		$readmemb("maze.mem", rom);
	end

	// registered read, data follows the address by one cycle
	always_ff @(posedge clock) begin
		row_data <= rom[row_addr];
	end

endmodule

// ==== design/maze_tile_walker.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// start is ignored while busy; positions wrap at the coordinate widths
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module maze_tile_walker import maze_pkg::*; (
	input logic clock,
	input logic resetn,
	input logic start,
	input coord_t origin,
	input map_row_t map_row,
	output logic [MAP_ADDR_BITS-1:0] map_row_addr,
	output pixel_t pixel,
	output logic plot,
	output logic busy,
	output logic done
);

	logic scanning; // counters are stepping
	logic [OFFSET_BITS-1:0] dx;
	logic [OFFSET_BITS-1:0] dy;
	logic [COL_BITS-1:0] tile_col;
	logic [MAP_ADDR_BITS-1:0] tile_row;
	coord_t origin_q;
	coord_t scan_pos;
	logic last_pos;
	logic launch;

	// stage 1 waits here for the ROM row
	logic s1_valid;
	logic s1_last;
	logic [COL_BITS-1:0] s1_col;
	coord_t s1_pos;

	logic s2_last;
	logic on_screen;

	assign launch = start && !busy;

	assign last_pos = (dx == OFFSET_BITS'(TILE_SIZE - 1)) &&
		(dy == OFFSET_BITS'(TILE_SIZE - 1)) &&
		(tile_col == COL_BITS'(MAZE_COLS - 1)) &&
		(tile_row == MAP_ADDR_BITS'(MAZE_ROWS - 1));

	// origin + tile * TILE_SIZE + offset, truncated
	assign scan_pos.x = origin_q.x + X_BITS'(tile_col) * X_BITS'(TILE_SIZE) + X_BITS'(dx);
	assign scan_pos.y = origin_q.y + Y_BITS'(tile_row) * Y_BITS'(TILE_SIZE) + Y_BITS'(dy);

	assign map_row_addr = tile_row;

	// dx fastest, then dy, tile column, tile row
	always_ff @(posedge clock) begin
		if (!resetn) begin
			scanning <= 1'b0;
			dx <= '0;
			dy <= '0;
			tile_col <= '0;
			tile_row <= '0;
		end else if (launch) begin
			scanning <= 1'b1;
			dx <= '0;
			dy <= '0;
			tile_col <= '0;
			tile_row <= '0;
		end else if (scanning) begin
			if (last_pos)
				scanning <= 1'b0;
			if (dx == OFFSET_BITS'(TILE_SIZE - 1)) begin
				dx <= '0;
				if (dy == OFFSET_BITS'(TILE_SIZE - 1)) begin
					dy <= '0;
					if (tile_col == COL_BITS'(MAZE_COLS - 1)) begin
						tile_col <= '0;
						if (tile_row == MAP_ADDR_BITS'(MAZE_ROWS - 1))
							tile_row <= '0;
						else
							tile_row <= tile_row + 1'b1;
					end else begin
						tile_col <= tile_col + 1'b1;
					end
				end else begin
					dy <= dy + 1'b1;
				end
			end else begin
				dx <= dx + 1'b1;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (launch)
			origin_q <= origin; // held for the whole draw
		s1_pos <= scan_pos;
		s1_col <= tile_col;
	end

	assign on_screen = (s1_pos.x < X_BITS'(SCREEN_W)) && (s1_pos.y < Y_BITS'(SCREEN_H));

	always_ff @(posedge clock) begin
		if (!resetn) begin
			s1_valid <= 1'b0;
			s1_last <= 1'b0;
			s2_last <= 1'b0;
			plot <= 1'b0;
			done <= 1'b0;
			busy <= 1'b0;
		end else begin
			s1_valid <= scanning;
			s1_last <= scanning && last_pos;
			s2_last <= s1_last;
			plot <= s1_valid && on_screen; // off-screen pixels still take their cycle
			done <= s2_last;
			if (launch)
				busy <= 1'b1;
			else if (s2_last)
				busy <= 1'b0; // drops together with done
		end
	end

	// pixel holds its last value between draws
	always_ff @(posedge clock) begin
		if (s1_valid) begin
			pixel.pos <= s1_pos;
			pixel.color <= map_row[s1_col] ? WALL_COLOR : FLOOR_COLOR;
		end
	end

endmodule

// ==== design/canvas_ram.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// coordinates must be on-screen; read during write gives old data
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module canvas_ram import maze_pkg::*; (
	input logic clock,
	input pixel_t write_pixel,
	input logic write_en,
	input coord_t read_pos,
	output logic [COLOR_BITS-1:0] read_color
);

	logic [COLOR_BITS-1:0] mem [SCREEN_W * SCREEN_H];

	logic [CANVAS_ADDR_BITS-1:0] write_addr;
	logic [CANVAS_ADDR_BITS-1:0] read_addr;

	// row-major linear address
	function automatic logic [CANVAS_ADDR_BITS-1:0] linear_addr(input coord_t pos);
		linear_addr = CANVAS_ADDR_BITS'(pos.y) * CANVAS_ADDR_BITS'(SCREEN_W)
			+ CANVAS_ADDR_BITS'(pos.x);
	endfunction

	assign write_addr = linear_addr(write_pixel.pos);
	assign read_addr = linear_addr(read_pos);

	always_ff @(posedge clock) begin
		if (write_en)
			mem[write_addr] <= write_pixel.color;
	end

	always_ff @(posedge clock) begin
		read_color <= mem[read_addr]; // one cycle latency
	end

endmodule

// ==== design/maze_display.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// start to done is 24130 cycles; no VGA output, canvas is read back by coordinate
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module maze_display import maze_pkg::*; (
	input logic clock,
	input logic resetn,
	input logic [7:0] switches,
	input logic load_y,
	input logic load_x,
	input logic start,
	input coord_t read_pos,
	output seg_t hex3,
	output seg_t hex2,
	output seg_t hex1,
	output seg_t hex0,
	output pixel_t pixel,
	output logic plot,
	output logic busy,
	output logic done,
	output logic [COLOR_BITS-1:0] read_color
);

	coord_t origin;
	logic [MAP_ADDR_BITS-1:0] map_row_addr;
	map_row_t map_row;

	coord_entry u_entry (
		.clock(clock),
		.resetn(resetn),
		.switches(switches),
		.load_y(load_y),
		.load_x(load_x),
		.origin(origin),
		.hex_x_hi(hex3),
		.hex_x_lo(hex2),
		.hex_y_hi(hex1),
		.hex_y_lo(hex0)
	);

	maze_map_rom u_rom (
		.clock(clock),
		.row_addr(map_row_addr),
		.row_data(map_row)
	);

	maze_tile_walker u_walker (
		.clock(clock),
		.resetn(resetn),
		.start(start),
		.origin(origin),
		.map_row(map_row),
		.map_row_addr(map_row_addr),
		.pixel(pixel),
		.plot(plot),
		.busy(busy),
		.done(done)
	);

	// plot already excludes off-screen pixels
	canvas_ram u_canvas (
		.clock(clock),
		.write_pixel(pixel),
		.write_en(plot),
		.read_pos(read_pos),
		.read_color(read_color)
	);

endmodule

// ==== sim/maze_display_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// reads design/maze.mem from the project root as reference map
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps

module maze_display_tb import maze_pkg::*; ();

	localparam int SCAN_LEN = TILE_SIZE * TILE_SIZE * MAZE_COLS * MAZE_ROWS; // 24128
	localparam int DRAW_CYCLES = SCAN_LEN + 2;
	localparam int DONE_TIMEOUT = 30000;

	// active-low hex digits, g down to a
	localparam logic [6:0] SEG_REF [16] = '{
		7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
		7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0e
	};

	logic clock;
	logic resetn;
	logic [7:0] switches;
	logic load_y;
	logic load_x;
	logic start;
	coord_t read_pos;
	seg_t hex3, hex2, hex1, hex0;
	pixel_t pixel;
	logic plot;
	logic busy;
	logic done;
	logic [COLOR_BITS-1:0] read_color;

	map_row_t ref_map [MAZE_ROWS];
	integer seed = 32'had7f952f;
	int errors;
	int checks;
	logic [X_BITS-1:0] ox; // model of the latched origin
	logic [Y_BITS-1:0] oy;

	maze_display DUT (
		.clock(clock), .resetn(resetn), .switches(switches),
		.load_y(load_y), .load_x(load_x), .start(start), .read_pos(read_pos),
		.hex3(hex3), .hex2(hex2), .hex1(hex1), .hex0(hex0),
		.pixel(pixel), .plot(plot), .busy(busy), .done(done), .read_color(read_color)
	);

	initial begin
		clock = 1'b0;
		forever #20 clock = ~clock;
	end

	task automatic log_failure(input string what);
		errors++;
		$display("%s", what);
	endtask

	a_done_pulse: assert property (@(posedge clock) disable iff (!resetn) done |=> !done)
		else log_failure("done stayed high for two cycles");
	a_done_busy: assert property (@(posedge clock) disable iff (!resetn) done |-> !busy)
		else log_failure("busy still high during done");
	a_plot_busy: assert property (@(posedge clock) disable iff (!resetn) plot |-> busy)
		else log_failure("plot raised outside a draw");
	a_plot_screen: assert property (@(posedge clock) disable iff (!resetn)
		plot |-> (pixel.pos.x < SCREEN_W && pixel.pos.y < SCREEN_H))
		else log_failure("plotted pixel lies off screen");

	task automatic expect_hex(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		assert (actual === expected) else begin
			errors++;
			$display("mismatch %s: expected %h, got %h", name, expected, actual);
		end
	endtask

	// scan index k to pixel: dx fastest, then dy, column, row
	function automatic pixel_t expected_pixel(input coord_t org, input int k);
		int dx, dy, col, row;
		pixel_t p;
		dx = k % TILE_SIZE;
		dy = (k / TILE_SIZE) % TILE_SIZE;
		col = (k / (TILE_SIZE * TILE_SIZE)) % MAZE_COLS;
		row = k / (TILE_SIZE * TILE_SIZE * MAZE_COLS);
		p.pos.x = X_BITS'(int'(org.x) + col * TILE_SIZE + dx);
		p.pos.y = Y_BITS'(int'(org.y) + row * TILE_SIZE + dy);
		p.color = ref_map[row][col] ? WALL_COLOR : FLOOR_COLOR;
		return p;
	endfunction

	function automatic bit on_screen(input coord_t pos);
		return (int'(pos.x) < SCREEN_W) && (int'(pos.y) < SCREEN_H);
	endfunction

	function automatic int count_on_screen(input coord_t org);
		int total;
		pixel_t p;
		total = 0;
		for (int k = 0; k < SCAN_LEN; k++) begin
			p = expected_pixel(org, k);
			if (on_screen(p.pos))
				total++;
		end
		return total;
	endfunction

	task automatic check_digits();
		expect_hex("hex3", 32'(SEG_REF[ox[7:4]]), 32'(hex3));
		expect_hex("hex2", 32'(SEG_REF[ox[3:0]]), 32'(hex2));
		expect_hex("hex1", 32'(SEG_REF[{1'b0, oy[6:4]}]), 32'(hex1));
		expect_hex("hex0", 32'(SEG_REF[oy[3:0]]), 32'(hex0));
	endtask

	task automatic load_coord(input bit is_x, input logic [7:0] value);
		@(posedge clock);
		#5;
		switches = value;
		load_x = is_x;
		load_y = !is_x;
		@(posedge clock);
		#5;
		load_x = 1'b0;
		load_y = 1'b0;
		if (is_x)
			ox = {1'b0, value};
		else
			oy = {1'b0, value[6:0]};
		@(negedge clock);
		check_digits();
	endtask

	// one draw from the model origin; optional second start while busy
	task automatic run_draw(input bit retrigger);
		coord_t org;
		pixel_t exp_p;
		int n;
		int plots;
		bit finished;
		org.x = ox;
		org.y = oy;
		n = -1; // cycles after the edge that samples start
		plots = 0;
		finished = 1'b0;
		@(posedge clock);
		#5;
		start = 1'b1;
		while (!finished && n < DONE_TIMEOUT) begin
			@(posedge clock);
			#5;
			start = retrigger && (n == 1000);
			@(negedge clock);
			n++;
			if (done) begin
				finished = 1'b1;
				expect_hex("done cycle", 32'(DRAW_CYCLES), 32'(n));
			end else begin
				expect_hex("busy", 32'h1, 32'(busy));
				if (n >= 2 && n < DRAW_CYCLES) begin
					exp_p = expected_pixel(org, n - 2);
					expect_hex("plot", 32'(on_screen(exp_p.pos)), 32'(plot));
					if (plot) begin
						plots++;
						expect_hex("pixel", 32'(exp_p), 32'(pixel));
					end
				end else begin
					expect_hex("plot", 32'h0, 32'(plot));
				end
			end
		end
		start = 1'b0;
		if (!finished) begin
			errors++;
			$display("timeout: done did not rise within %0d cycles", DONE_TIMEOUT);
		end
		expect_hex("plot count", 32'(count_on_screen(org)), 32'(plots));
	endtask

	// maze area only, the rest of the canvas is undefined
	task automatic check_readback(input int samples);
		int x, y;
		logic [COLOR_BITS-1:0] exp_color;
		for (int i = 0; i < samples; i++) begin
			x = int'($unsigned($random(seed)) % (MAZE_COLS * TILE_SIZE));
			y = int'($unsigned($random(seed)) % (MAZE_ROWS * TILE_SIZE));
			exp_color = ref_map[y / TILE_SIZE][x / TILE_SIZE] ? WALL_COLOR : FLOOR_COLOR;
			@(posedge clock);
			#5;
			read_pos.x = X_BITS'(x);
			read_pos.y = Y_BITS'(y);
			@(posedge clock);
			@(negedge clock);
			expect_hex("read_color", 32'(exp_color), 32'(read_color));
		end
	endtask

	initial begin
		resetn = 1'b0;
		switches = '0;
		load_y = 1'b0;
		load_x = 1'b0;
		start = 1'b0;
		read_pos = '0;
		errors = 0;
		checks = 0;
		ox = '0;
		oy = '0;
		$readmemb("design/maze.mem", ref_map);
		repeat (8) @(posedge clock);
		#5;
		resetn = 1'b1;

		@(negedge clock);
		expect_hex("plot", 32'h0, 32'(plot));
		expect_hex("busy", 32'h0, 32'(busy));
		expect_hex("done", 32'h0, 32'(done));
		check_digits();

		repeat (6) begin
			load_coord(1'b0, 8'($random(seed)));
			load_coord(1'b1, 8'($random(seed))); // y must survive this
		end
		run_draw(1'b1);

		load_coord(1'b0, 8'd127); // clipped at the right edge
		load_coord(1'b1, 8'd200);
		run_draw(1'b0);

		load_coord(1'b0, 8'd0);
		load_coord(1'b1, 8'd0);
		run_draw(1'b0);
		check_readback(48);

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// ==== design/maze.mem ====
// 13 rows of 29 wall bits, top line is tile row 0
// rightmost digit is tile column 0, 1 marks a wall
11111111111111111111111111111
10000010000000000010000000001
10111010111111101010111111101
10100010000000100010100000101
10101111111010111010101110101
10100000001010000010001000101
10111111101011111111111011101
10000000101000000000000010001
11111110101111111101111110101
10000010100000000100000010101
10111010111111110111111010101
10100000000000000000000010001
11111111111111111111111111111

// ==== maze_display.f ====
design/maze_pkg.sv
design/coord_entry.sv
design/maze_map_rom.sv
design/maze_tile_walker.sv
design/canvas_ram.sv
design/maze_display.sv
sim/maze_display_tb.sv

// ==== Makefile ====
.PHONY: sim clean

# the map ROM opens maze.mem in the working directory
sim:
	cp design/maze.mem maze.mem
	verilator --binary --timing --assert -Wno-fatal --top-module maze_display_tb \
		-f maze_display.f -o maze_sim
	obj_dir/maze_sim | tee sim.log
	grep -q "Test completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log maze.mem
